/* src/dh_kin_pkg.sv */
// Shared fixed-point types, the joint parameter record and the sequencer states
// for the DH forward kinematics core. Compile ahead of every RTL module,
// which refer to these by dh_kin_pkg:: scoped names.
`default_nettype none

package dh_kin_pkg;

	localparam int FIX_W = 24;
	localparam int FRAC = 14; // fraction bits

	typedef logic signed [FIX_W-1:0] fix_t;

	localparam fix_t ONE = fix_t'(1 << FRAC);

	// 256 steps per full turn
	typedef logic [7:0] angle_t;

	// one joint, 64 bits
	typedef struct packed {
		fix_t a;
		fix_t d;
		angle_t alpha;
		angle_t theta;
	} dh_param_t;

	// indexed [row][col]
	typedef fix_t [3:0][3:0] mat4_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LINK,  // waiting for link matrix
		S_MULT,  // multiply running
		S_STORE  // write pose, next joint
	} seq_state_t;

endpackage

`default_nettype wire

/* src/dh_param_regs.sv */
// Joint parameter register file. The host writes one joint per wr_en strobe
// while the core is idle; the sequencer reads by joint index, combinationally.
`default_nettype none

module dh_param_regs #(
	parameter int N_JOINT = 6,
	localparam int JW = (N_JOINT > 1) ? $clog2(N_JOINT) : 1
) (
	input wire logic i,
	input wire logic rst_n,
	input wire logic wr_en,
	input wire logic [JW-1:0] wr_joint,
	input wire dh_kin_pkg::dh_param_t wr_param,
	input wire logic busy,
	input wire logic [JW-1:0] joint_sel,
	output dh_kin_pkg::dh_param_t param
);

	dh_kin_pkg::dh_param_t regs [N_JOINT];

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			for (int j = 0; j < N_JOINT; j++) begin
				regs[j] <= '0;
			end
		end else if (wr_en && !busy && (wr_joint < N_JOINT)) begin
			regs[wr_joint] <= wr_param; // dropped while a run is going
		end
	end

	always_comb begin
		if (joint_sel < N_JOINT) begin
			param = regs[joint_sel];
		end else begin
			param = '0;
		end
	end

	// host must stay inside the arm
	a_wr_joint_range: assert property (
		@(posedge i) disable iff (!rst_n)
		wr_en |-> (wr_joint < N_JOINT)
	) else $error("parameter write to joint %0d, only %0d joints", wr_joint, N_JOINT);

endmodule

`default_nettype wire

/* src/sin_cos_rom.sv */
// Sine and cosine of one 8-bit angle from a quarter-wave table.
// The table (65 entries, 14 fraction bits) is loaded from sin_table.hex.
// Both outputs are registered, so results appear one cycle after ang.
`default_nettype none

module sin_cos_rom (
	input wire logic i,
	input wire logic rst_n,
	input wire dh_kin_pkg::angle_t ang,
	output dh_kin_pkg::fix_t sin_v,
	output dh_kin_pkg::fix_t cos_v
);

	dh_kin_pkg::fix_t rom [0:64];

	initial begin
		$readmemh("sin_table.hex", rom);
	end

	// quadrant folding into the first quarter wave
	function automatic dh_kin_pkg::fix_t fold_sin(input dh_kin_pkg::angle_t a);
		logic [6:0] idx;
		dh_kin_pkg::fix_t v;
		if (a[6]) begin
			idx = 7'd64 - {1'b0, a[5:0]}; // falling half, mirror
		end else begin
			idx = {1'b0, a[5:0]};
		end
		v = rom[idx];
		return a[7] ? -v : v; // lower half turn is negative
	endfunction

	dh_kin_pkg::angle_t ang_cos;

	assign ang_cos = ang + 8'd64; // cos(x) = sin(x + quarter turn), wraps

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			sin_v <= '0;
			cos_v <= '0;
		end else begin
			sin_v <= fold_sin(ang);
			cos_v <= fold_sin(ang_cos);
		end
	end

endmodule

`default_nettype wire

/* src/dh_link_mat.sv */
// Builds the 4x4 DH link transform of one joint. The parameters are sampled
// on link_go; link_mat is updated and link_valid pulses three cycles later.
// Pipeline: table lookup, trig products, then a/d products into the matrix.
`default_nettype none

module dh_link_mat (
	input wire logic i,
	input wire logic rst_n,
	input wire logic link_go,
	input wire dh_kin_pkg::dh_param_t param,
	output dh_kin_pkg::mat4_t link_mat,
	output logic link_valid
);

	// full width product, one shift, truncates toward minus infinity
	function automatic dh_kin_pkg::fix_t mulf(input dh_kin_pkg::fix_t x,
			input dh_kin_pkg::fix_t y);
		logic signed [2*dh_kin_pkg::FIX_W-1:0] p;
		p = x * y;
		return dh_kin_pkg::fix_t'(p >>> dh_kin_pkg::FRAC);
	endfunction

	dh_kin_pkg::fix_t st, ct, sa, ca;
	dh_kin_pkg::fix_t a1, d1;
	dh_kin_pkg::fix_t st2, ct2, sa2, ca2, a2, d2;
	dh_kin_pkg::fix_t n_stca, stsa, ctca, n_ctsa;
	logic [2:0] vld;

	sin_cos_rom i_rom_theta (
		.i     (i),
		.rst_n (rst_n),
		.ang   (param.theta),
		.sin_v (st),
		.cos_v (ct)
	);

	sin_cos_rom i_rom_alpha (
		.i     (i),
		.rst_n (rst_n),
		.ang   (param.alpha),
		.sin_v (sa),
		.cos_v (ca)
	);

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[1:0], link_go};
		end
	end

	assign link_valid = vld[2];

	// stage 1 runs alongside the table lookup
	always_ff @(posedge i) begin
		if (link_go) begin
			a1 <= param.a;
			d1 <= param.d;
		end
	end

	always_ff @(posedge i) begin
		if (vld[0]) begin
			st2 <= st;
			ct2 <= ct;
			sa2 <= sa;
			ca2 <= ca;
			a2 <= a1;
			d2 <= d1;
			n_stca <= mulf(-st, ca); // sign goes in before the shift
			stsa <= mulf(st, sa);
			ctca <= mulf(ct, ca);
			n_ctsa <= mulf(-ct, sa);
		end
	end

	always_ff @(posedge i) begin
		if (vld[1]) begin
			link_mat[0][0] <= ct2;
			link_mat[0][1] <= n_stca;
			link_mat[0][2] <= stsa;
			link_mat[0][3] <= mulf(a2, ct2);
			link_mat[1][0] <= st2;
			link_mat[1][1] <= ctca;
			link_mat[1][2] <= n_ctsa;
			link_mat[1][3] <= mulf(a2, st2);
			link_mat[2][0] <= '0;
			link_mat[2][1] <= sa2;
			link_mat[2][2] <= ca2;
			link_mat[2][3] <= d2;
			link_mat[3] <= '0;
			link_mat[3][3] <= dh_kin_pkg::ONE;
		end
	end

endmodule

`default_nettype wire

/* src/mat4_mult.sv */
// Sequential 4x4 fixed-point matrix product, mult_res = mult_a * mult_b.
// One element per cycle, first one in the mult_go cycle itself, so
// mult_valid pulses 16 cycles after mult_go. mult_res holds until next go.
`default_nettype none

module mat4_mult (
	input wire logic i,
	input wire logic rst_n,
	input wire logic mult_go,
	input wire dh_kin_pkg::mat4_t mult_a,
	input wire dh_kin_pkg::mat4_t mult_b,
	output dh_kin_pkg::mat4_t mult_res,
	output logic mult_valid
);

	dh_kin_pkg::mat4_t a_q, b_q;
	dh_kin_pkg::mat4_t op_a, op_b;
	logic running;
	logic [3:0] cnt; // {row, col}
	logic [1:0] row, col;
	logic signed [2*dh_kin_pkg::FIX_W+1:0] acc;

	assign row = cnt[3:2];
	assign col = cnt[1:0];
	assign op_a = mult_go ? mult_a : a_q; // element 0 straight from inputs
	assign op_b = mult_go ? mult_b : b_q;

	always_comb begin
		acc = '0;
		for (int k = 0; k < 4; k++) begin
			acc = acc + $signed(op_a[row][k]) * $signed(op_b[k][col]);
		end
	end

	always_ff @(posedge i) begin
		if (mult_go) begin
			a_q <= mult_a;
			b_q <= mult_b;
		end
		if (mult_go || running) begin
			mult_res[row][col] <= dh_kin_pkg::fix_t'(acc >>> dh_kin_pkg::FRAC);
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt <= '0;
			mult_valid <= 1'b0;
		end else begin
			mult_valid <= 1'b0;
			if (mult_go || running) begin
				cnt <= cnt + 4'd1; // wraps back to 0 after element 15
				running <= (cnt != 4'd15);
				mult_valid <= (cnt == 4'd15);
			end
		end
	end

	a_no_overlap: assert property (
		@(posedge i) disable iff (!rst_n)
		mult_go |-> !running
	) else $error("mult_go while a multiply is still running");

endmodule

`default_nettype wire

/* src/chain_seq.sv */
// Sequencer for the kinematic chain. On start it walks joints 0..N_JOINT-1:
// fetch parameters and build the link matrix, multiply it into the running
// product, then hand the new product to the pose store. 21 cycles per joint.
`default_nettype none

module chain_seq #(
	parameter int N_JOINT = 6,
	localparam int JW = (N_JOINT > 1) ? $clog2(N_JOINT) : 1
) (
	input wire logic i,
	input wire logic rst_n,
	input wire logic start,
	input wire dh_kin_pkg::dh_param_t param,
	input wire dh_kin_pkg::mat4_t link_mat,
	input wire logic link_valid,
	input wire dh_kin_pkg::mat4_t mult_res,
	input wire logic mult_valid,
	output logic busy,
	output logic [JW-1:0] joint_sel,
	output logic link_go,
	output logic mult_go,
	output dh_kin_pkg::mat4_t mult_a,
	output dh_kin_pkg::mat4_t mult_b,
	output logic pose_we,
	output logic [JW-1:0] pose_joint,
	output dh_kin_pkg::mat4_t pose_val,
	output logic last
);

	function automatic dh_kin_pkg::mat4_t identity();
		dh_kin_pkg::mat4_t m;
		m = '0;
		for (int k = 0; k < 4; k++) begin
			m[k][k] = dh_kin_pkg::ONE;
		end
		return m;
	endfunction

	dh_kin_pkg::seq_state_t state;
	logic [JW-1:0] joint_cnt;
	dh_kin_pkg::mat4_t run_prod; // base to current joint

	assign joint_sel = joint_cnt;
	assign pose_joint = joint_cnt;
	assign pose_val = run_prod; // already holds this joint's product in S_STORE
	assign mult_a = run_prod;
	assign mult_b = link_mat;
	assign mult_go = (state == dh_kin_pkg::S_LINK) && link_valid;

	always_ff @(posedge i) begin
		if (state == dh_kin_pkg::S_IDLE && start) begin
			run_prod <= identity();
		end else if (state == dh_kin_pkg::S_MULT && mult_valid) begin
			run_prod <= mult_res;
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state <= dh_kin_pkg::S_IDLE;
			joint_cnt <= '0;
			busy <= 1'b0;
			link_go <= 1'b0;
			pose_we <= 1'b0;
			last <= 1'b0;
		end else begin
			link_go <= 1'b0;
			pose_we <= 1'b0;
			last <= 1'b0;
			case (state)
				dh_kin_pkg::S_IDLE: begin
					if (start) begin
						joint_cnt <= '0;
						busy <= 1'b1;
						link_go <= 1'b1; // fetch cycle of joint 0
						state <= dh_kin_pkg::S_LINK;
					end
				end
				dh_kin_pkg::S_LINK: begin
					if (link_valid) begin
						state <= dh_kin_pkg::S_MULT;
					end
				end
				dh_kin_pkg::S_MULT: begin
					if (mult_valid) begin
						pose_we <= 1'b1;
						last <= (joint_cnt == JW'(N_JOINT - 1));
						state <= dh_kin_pkg::S_STORE;
					end
				end
				dh_kin_pkg::S_STORE: begin
					if (last) begin
						busy <= 1'b0; // drops in the done cycle
						state <= dh_kin_pkg::S_IDLE;
					end else begin
						joint_cnt <= joint_cnt + 1'b1;
						link_go <= 1'b1;
						state <= dh_kin_pkg::S_LINK;
					end
				end
				default: state <= dh_kin_pkg::S_IDLE;
			endcase
		end
	end

	a_last_with_store: assert property (
		@(posedge i) disable iff (!rst_n)
		last |-> pose_we && (pose_joint == JW'(N_JOINT - 1))
	) else $error("last without a store of the final joint");

endmodule

`default_nettype wire

/* src/pose_store.sv */
// Output side. Keeps the cumulative base-to-joint pose of every joint for
// combinational readback and turns the sequencer's last strobe into done.
`default_nettype none

module pose_store #(
	parameter int N_JOINT = 6,
	localparam int JW = (N_JOINT > 1) ? $clog2(N_JOINT) : 1
) (
	input wire logic i,
	input wire logic rst_n,
	input wire logic pose_we,
	input wire logic [JW-1:0] pose_joint,
	input wire dh_kin_pkg::mat4_t pose_val,
	input wire logic last,
	input wire logic [JW-1:0] rd_joint,
	output dh_kin_pkg::mat4_t rd_pose,
	output logic done
);

	dh_kin_pkg::mat4_t pose [N_JOINT];

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			for (int j = 0; j < N_JOINT; j++) begin
				pose[j] <= '0;
			end
			done <= 1'b0;
		end else begin
			if (pose_we && (pose_joint < N_JOINT)) begin
				pose[pose_joint] <= pose_val;
			end
			done <= last; // one cycle after the final store
		end
	end

	always_comb begin
		if (rd_joint < N_JOINT) begin
			rd_pose = pose[rd_joint];
		end else begin
			rd_pose = '0; // unused index
		end
	end

endmodule

`default_nettype wire

/* src/dh_kin_top.sv */
// Forward kinematics core for an N_JOINT serial arm from DH parameters.
// Write parameters while idle, pulse start, wait for done, then read the
// cumulative pose of any joint through rd_joint / rd_pose.
`default_nettype none

module dh_kin_top #(
	parameter int N_JOINT = 6,
	localparam int JW = (N_JOINT > 1) ? $clog2(N_JOINT) : 1
) (
	input wire logic i,
	input wire logic rst_n,
	input wire logic wr_en,
	input wire logic [JW-1:0] wr_joint,
	input wire dh_kin_pkg::dh_param_t wr_param,
	input wire logic start,
	output logic busy,
	output logic done,
	input wire logic [JW-1:0] rd_joint,
	output dh_kin_pkg::mat4_t rd_pose
);

	logic [JW-1:0] joint_sel;
	dh_kin_pkg::dh_param_t param;
	logic link_go, link_valid;
	dh_kin_pkg::mat4_t link_mat;
	logic mult_go, mult_valid;
	dh_kin_pkg::mat4_t mult_a, mult_b, mult_res;
	logic pose_we, last;
	logic [JW-1:0] pose_joint;
	dh_kin_pkg::mat4_t pose_val;

	dh_param_regs #(.N_JOINT(N_JOINT)) i_param_regs (
		.i, .rst_n, .wr_en, .wr_joint, .wr_param, .busy, .joint_sel, .param
	);

	dh_link_mat i_link_mat (
		.i, .rst_n, .link_go, .param, .link_mat, .link_valid
	);

	mat4_mult i_mat4_mult (
		.i, .rst_n, .mult_go, .mult_a, .mult_b, .mult_res, .mult_valid
	);

	chain_seq #(.N_JOINT(N_JOINT)) i_chain_seq (
		.i, .rst_n, .start, .param, .link_mat, .link_valid, .mult_res, .mult_valid,
		.busy, .joint_sel, .link_go, .mult_go, .mult_a, .mult_b,
		.pose_we, .pose_joint, .pose_val, .last
	);

	pose_store #(.N_JOINT(N_JOINT)) i_pose_store (
		.i, .rst_n, .pose_we, .pose_joint, .pose_val, .last, .rd_joint, .rd_pose, .done
	);

endmodule

`default_nettype wire

/* test/dh_kin_tb.sv */
// Directed testbench for the DH forward kinematics core. Writes joint
// parameters, starts a run, waits for done and compares every stored pose
// with a fixed-point reference model built from the DH rules.
`default_nettype none

module dh_kin_tb;

	localparam int N_JOINT = 6;
	localparam int JW = $clog2(N_JOINT);
	localparam int CYCLE_LIMIT = 8 * 200; // 8 runs, 200 cycles each

	logic i;
	logic rst_n;
	logic wr_en;
	logic [JW-1:0] wr_joint;
	dh_kin_pkg::dh_param_t wr_param;
	logic start;
	logic busy;
	logic done;
	logic [JW-1:0] rd_joint;
	dh_kin_pkg::mat4_t rd_pose;

	dh_kin_pkg::fix_t tab [0:64];
	dh_kin_pkg::dh_param_t arm [N_JOINT];
	dh_kin_pkg::mat4_t exp_pose [N_JOINT];

	integer seed;
	int cycles;
	int done_cnt;
	int check_cnt;
	int mismatch_cnt;
	int fail_cnt;
	string cur_test;

	dh_kin_top #(.N_JOINT(N_JOINT)) i_dh_kin_top (
		.i, .rst_n, .wr_en, .wr_joint, .wr_param, .start,
		.busy, .done, .rd_joint, .rd_pose
	);

	always #20 i = ~i;

	always @(posedge i) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: test %s never saw done within %0d cycles", cur_test, CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	always @(negedge i) begin
		if (done === 1'b1) begin
			done_cnt++;
		end
	end

	task automatic wait_cycle();
		@(posedge i);
		#5;
	endtask

	task automatic load_table();
		$readmemh("sin_table.hex", tab);
	endtask

	// quarter q of the turn picks mirror and sign
	function automatic longint table_sin(input int ang);
		int a;
		int q;
		int r;
		a = ang & 255;
		q = a / 64;
		r = a % 64;
		case (q)
			0: return tab[r];
			1: return tab[64 - r];
			2: return -tab[r];
			default: return -tab[64 - r];
		endcase
	endfunction

	function automatic dh_kin_pkg::fix_t fx_mul(input longint x, input longint y);
		return dh_kin_pkg::fix_t'((x * y) >>> 14);
	endfunction

	function automatic dh_kin_pkg::mat4_t link_matrix(input dh_kin_pkg::dh_param_t p);
		dh_kin_pkg::mat4_t m;
		longint st, ct, sa, ca;
		st = table_sin(int'(p.theta));
		ct = table_sin(int'(p.theta) + 64);
		sa = table_sin(int'(p.alpha));
		ca = table_sin(int'(p.alpha) + 64);
		m = '0;
		m[0][0] = dh_kin_pkg::fix_t'(ct);
		m[0][1] = fx_mul(-st, ca);
		m[0][2] = fx_mul(st, sa);
		m[0][3] = fx_mul(longint'(p.a), ct);
		m[1][0] = dh_kin_pkg::fix_t'(st);
		m[1][1] = fx_mul(ct, ca);
		m[1][2] = fx_mul(-ct, sa);
		m[1][3] = fx_mul(longint'(p.a), st);
		m[2][1] = dh_kin_pkg::fix_t'(sa);
		m[2][2] = dh_kin_pkg::fix_t'(ca);
		m[2][3] = p.d;
		m[3][3] = dh_kin_pkg::ONE;
		return m;
	endfunction

	// sum of four full-width products, then one shift
	function automatic dh_kin_pkg::mat4_t mat_product(input dh_kin_pkg::mat4_t x,
			input dh_kin_pkg::mat4_t y);
		dh_kin_pkg::mat4_t m;
		longint s;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				s = 0;
				for (int k = 0; k < 4; k++) begin
					s += longint'(x[r][k]) * longint'(y[k][c]);
				end
				m[r][c] = dh_kin_pkg::fix_t'(s >>> 14);
			end
		end
		return m;
	endfunction

	task automatic compute_chain();
		dh_kin_pkg::mat4_t run;
		run = '0;
		for (int k = 0; k < 4; k++) begin
			run[k][k] = dh_kin_pkg::ONE;
		end
		for (int j = 0; j < N_JOINT; j++) begin
			run = mat_product(run, link_matrix(arm[j]));
			exp_pose[j] = run;
		end
	endtask

	task automatic check_pose(input string name, input dh_kin_pkg::mat4_t exp_m,
			input dh_kin_pkg::mat4_t act_m);
		int bad_r;
		int bad_c;
		bad_r = -1;
		bad_c = 0;
		check_cnt++;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				if (act_m[r][c] !== exp_m[r][c] && bad_r < 0) begin
					bad_r = r;
					bad_c = c;
				end
			end
		end
		if (bad_r >= 0) begin
			mismatch_cnt++;
			$display("mismatch %s: element [%0d][%0d] expected %0d actual %0d", name, bad_r,
				bad_c, $signed(exp_m[bad_r][bad_c]), $signed(act_m[bad_r][bad_c]));
		end
	endtask

	task automatic check_bit(input string name, input logic exp_b, input logic act_b);
		check_cnt++;
		if (act_b !== exp_b) begin
			mismatch_cnt++;
			$display("mismatch %s: expected %b actual %b", name, exp_b, act_b);
		end
	endtask

	task automatic check_poses(input string name);
		for (int j = 0; j < N_JOINT; j++) begin
			rd_joint = JW'(j);
			#1;
			check_pose($sformatf("%s joint %0d", name, j), exp_pose[j], rd_pose);
		end
	endtask

	task automatic write_joint(input int j, input dh_kin_pkg::dh_param_t p);
		wr_en = 1'b1;
		wr_joint = JW'(j);
		wr_param = p;
		wait_cycle();
		wr_en = 1'b0;
	endtask

	task automatic load_arm();
		for (int j = 0; j < N_JOINT; j++) begin
			write_joint(j, arm[j]);
		end
	endtask

	task automatic launch();
		start = 1'b1;
		wait_cycle();
		start = 1'b0;
	endtask

	task automatic wait_done(input string name);
		cur_test = name;
		while (done !== 1'b1) begin
			wait_cycle();
		end
	endtask

	task automatic run_and_check(input string name);
		load_arm();
		compute_chain();
		launch();
		wait_done(name);
		check_bit({name, " busy at done"}, 1'b0, busy);
		check_poses(name);
		wait_cycle();
	endtask

	task automatic test_reset();
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset done", 1'b0, done);
		for (int j = 0; j < N_JOINT; j++) begin
			exp_pose[j] = '0;
		end
		check_poses("reset");
	endtask

	task automatic test_zero_angles();
		for (int j = 0; j < N_JOINT; j++) begin
			arm[j].a = dh_kin_pkg::fix_t'((j + 1) * 4096); // quarter steps
			arm[j].d = dh_kin_pkg::fix_t'(2048 * j - 3000);
			arm[j].alpha = 8'd0;
			arm[j].theta = 8'd0;
		end
		run_and_check("zero angles");
	endtask

	task automatic test_quadrants();
		int th_a [N_JOINT] = '{0, 64, 128, 192, 21, 85};
		int al_a [N_JOINT] = '{192, 128, 64, 0, 107, 171};
		int th_b [N_JOINT] = '{149, 213, 1, 63, 127, 255};
		int al_b [N_JOINT] = '{43, 235, 170, 65, 191, 129};
		for (int j = 0; j < N_JOINT; j++) begin
			arm[j].a = dh_kin_pkg::fix_t'(5000 - 1700 * j);
			arm[j].d = dh_kin_pkg::fix_t'(900 * j + 300);
			arm[j].alpha = 8'(al_a[j]);
			arm[j].theta = 8'(th_a[j]);
		end
		run_and_check("quadrants axes");
		for (int j = 0; j < N_JOINT; j++) begin
			arm[j].alpha = 8'(al_b[j]);
			arm[j].theta = 8'(th_b[j]);
		end
		run_and_check("quadrants odd");
	endtask

	task automatic random_arm();
		for (int j = 0; j < N_JOINT; j++) begin
			arm[j].a = dh_kin_pkg::fix_t'($random(seed) % 32768); // within +-2.0
			arm[j].d = dh_kin_pkg::fix_t'($random(seed) % 32768);
			arm[j].alpha = 8'($random(seed));
			arm[j].theta = 8'($random(seed));
		end
	endtask

	task automatic test_random_arm();
		for (int n = 0; n < 3; n++) begin
			random_arm();
			run_and_check($sformatf("random arm %0d", n));
		end
	endtask

	task automatic test_busy_lockout();
		int n;
		random_arm();
		load_arm();
		compute_chain();
		done_cnt = 0;
		cur_test = "busy lockout";
		launch();
		n = 0;
		while (done !== 1'b1) begin
			check_bit("busy lockout busy high", 1'b1, busy);
			n++;
			start = (n == 3); // second start mid-run
			if (n >= 10 && n < 16) begin
				wr_en = 1'b1;
				wr_joint = JW'(n - 10);
				wr_param = {24'($random(seed)), 24'($random(seed)), 16'($random(seed))};
			end else begin
				wr_en = 1'b0;
			end
			wait_cycle();
		end
		check_bit("busy lockout busy at done", 1'b0, busy);
		check_poses("busy lockout");
		repeat (30) wait_cycle();
		check_bit("busy lockout idle after done", 1'b0, busy);
		if (done_cnt != 1) begin
			fail_cnt++;
			$display("done pulsed %0d times during one run instead of once", done_cnt);
		end
		// a rerun proves the blocked writes never reached the registers
		launch();
		wait_done("busy lockout rerun");
		check_poses("busy lockout rerun");
		wait_cycle();
	endtask

	initial begin
		i = 1'b0;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_joint = '0;
		wr_param = '0;
		start = 1'b0;
		rd_joint = '0;
		seed = 32'h17fe_dc4e;
		cycles = 0;
		done_cnt = 0;
		check_cnt = 0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		cur_test = "reset";
		load_table();
		repeat (3) @(posedge i);
		#5;
		rst_n = 1'b1;
		wait_cycle();

		test_reset();
		test_zero_angles();
		test_quadrants();
		test_random_arm();
		test_busy_lockout();

		$display("summary: %0d checks, %0d mismatches, %0d other errors", check_cnt,
			mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dh_kin.f */
src/dh_kin_pkg.sv
src/dh_param_regs.sv
src/sin_cos_rom.sv
src/dh_link_mat.sv
src/mat4_mult.sv
src/chain_seq.sv
src/pose_store.sv
src/dh_kin_top.sv
test/dh_kin_tb.sv

/* Bender.yml */
package:
  name: dh_kin

sources:
  - src/dh_kin_pkg.sv
  - src/dh_param_regs.sv
  - src/sin_cos_rom.sv
  - src/dh_link_mat.sv
  - src/mat4_mult.sv
  - src/chain_seq.sv
  - src/pose_store.sv
  - src/dh_kin_top.sv
  - target: test
    files:
      - test/dh_kin_tb.sv

/* sin_table.hex */
// one column: round(sin(k * 90deg / 64) * 2^14) for k = 0..64, 24-bit hex
000000
000192
000324
0004b5
000646
0007d6
000964
000af1
000c7c
000e06
000f8d
001112
001294
001413
001590
001709
00187e
0019ef
001b5d
001cc6
001e2b
001f8c
0020e7
00223d
00238e
0024da
002620
002760
00289a
0029ce
002afb
002c21
002d41
002e5a
002f6c
003076
003179
003274
003368
003453
003537
003612
0036e5
0037b0
003871
00392b
0039db
003a82
003b21
003bb6
003c42
003cc5
003d3f
003daf
003e15
003e72
003ec5
003f0f
003f4f
003f85
003fb1
003fd4
003fec
003ffb
004000
